// ==== Bender.yml ====
package:
  name: stm_timer

sources:
  - files:
      - verilog/stm_pkg.sv
      - verilog/pipe_divider.sv
      - verilog/settle_counter.sv
      - verilog/stm_settings_fsm.sv
      - verilog/stm_index_calc.sv
      - verilog/stm_timer.sv
  - target: test
    files:
      - bench/stm_timer_tb.sv

// ==== bench/stm_timer_tb.sv ====
`timescale 1ns/1ps
module stm_timer_tb;
  import stm_pkg::*;

  localparam int clk_period = 40;
  localparam int drive_delay = 5;
  localparam int reset_cycles = 10;
  localparam int num_requests = 8;
  localparam int num_load_requests = 2;
  localparam int load_req_delay = 40;  // cycles after an accepted request, well inside LOAD
  localparam int check_cycles = 56;
  localparam int zero_cycle_req = 3;  // this request gives the last segment a cycle of zero
  localparam int hist_len = 2 * div_latency + 1;
  localparam int run_cycles = reset_cycles + num_requests * (settle_latency + 2 + check_cycles);
  localparam int timeout_cycles = run_cycles + run_cycles / 2;

  logic CLK;
  logic reset;
  logic update_settings_in;
  sys_time_t sys_time;
  stm_settings_t settings [num_segment];
  idx_t idx [num_segment];
  logic update_settings_out;

  logic [15:0] lfsr_state;
  sys_time_t time_hist [hist_len];  // [0] is the newest sample
  stm_settings_t model_settings [num_segment];
  int wait_cnt;
  logic exp_done;
  logic check_en;
  int done_count;
  int rel_cycles;
  int cycle_count = 0;

  stm_timer stm_timer_i (
    .CLK                (CLK),
    .reset              (reset),
    .update_settings_in (update_settings_in),
    .sys_time           (sys_time),
    .settings           (settings),
    .idx                (idx),
    .update_settings_out(update_settings_out)
  );

  initial begin
    CLK = 1'b0;
    forever #(clk_period / 2) CLK = ~CLK;
  end

  task automatic fail_run();
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    fail_run();
  endtask

  // 16 bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // index of one segment for a given time, straight from the definition
  function automatic idx_t ref_index(input sys_time_t t, input stm_settings_t s);
    logic [63:0] ticks;
    logic [63:0] count;
    ticks = 64'(t >> time_shift);
    count = ticks / 64'(s.freq_div);
    return idx_t'(count % (64'(s.cycle) + 64'd1));
  endfunction

  task automatic tick();
    logic [31:0] step;
    @(posedge CLK);
    #drive_delay;
    update_settings_in = 1'b0;
    draw_bits(6, step);
    sys_time = sys_time + (sys_time_t'(step[5:0]) << time_shift);
  endtask

  task automatic issue_request(input bit zero_last_cycle);
    logic [31:0] fd;
    logic [31:0] cy;
    for (int i = 0; i < num_segment; i++) begin
      draw_bits(4, fd);
      draw_bits(idx_w, cy);
      if (fd[3:0] == 4'd0) begin
        fd = 32'd1;
      end
      settings[i].freq_div = divisor_t'(fd[3:0]);
      settings[i].cycle = cycle_t'(cy);
    end
    if (zero_last_cycle) begin
      settings[num_segment-1].cycle = '0;
    end
    update_settings_in = 1'b1;
  endtask

  always @(posedge CLK) begin
    time_hist[0] <= sys_time;
    for (int k = 1; k < hist_len; k++) begin
      time_hist[k] <= time_hist[k-1];
    end
  end

  // reference for the request and done timing and the settings in force
  always @(posedge CLK) begin
    if (reset) begin
      wait_cnt <= 0;
      exp_done <= 1'b0;
      check_en <= 1'b0;
      done_count <= 0;
      rel_cycles <= 0;
      for (int i = 0; i < num_segment; i++) begin
        model_settings[i] <= '{freq_div: divisor_t'(1), cycle: '0};
      end
    end else begin
      rel_cycles <= rel_cycles + 1;
      exp_done <= 1'b0;
      if (exp_done) begin
        check_en <= 1'b1;  // every index now comes from the new settings
      end
      if (update_settings_out) begin
        done_count <= done_count + 1;
      end
      if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1;  // requests are dropped while the update is pending
        if (wait_cnt == 1) begin
          exp_done <= 1'b1;
        end
      end else if (update_settings_in) begin
        wait_cnt <= settle_latency + 1;
        model_settings <= settings;
        check_en <= 1'b0;
      end
    end
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == timeout_cycles) begin
      $display("timeout: the test sequence did not finish within %0d cycles", timeout_cycles);
      fail_run();
    end
  end

  a_done_timing: assert property (
    @(posedge CLK) disable iff (reset) update_settings_out == exp_done
  ) else report_mismatch("update_settings_out", $sampled(update_settings_out),
                         $sampled(exp_done));

  for (genvar i = 0; i < num_segment; i++) begin : gen_check
    idx_t expected;

    assign expected = ref_index(time_hist[hist_len-1], model_settings[i]);

    // no index result leaves the pipeline before this
    a_idx_start: assert property (
      @(posedge CLK) disable iff (reset) (rel_cycles < hist_len) |-> idx[i] == '0
    ) else report_mismatch($sformatf("idx[%0d]", i), $sampled(idx[i]), 0);

    a_idx_model: assert property (
      @(posedge CLK) disable iff (reset) check_en |-> idx[i] == expected
    ) else report_mismatch($sformatf("idx[%0d]", i), $sampled(idx[i]), $sampled(expected));

    a_idx_zero_cycle: assert property (
      @(posedge CLK) disable iff (reset)
        (check_en && model_settings[i].cycle == '0) |-> idx[i] == '0
    ) else report_mismatch($sformatf("idx[%0d]", i), $sampled(idx[i]), 0);
  end

  initial begin
    int dones;
    int waited;
    lfsr_state = 16'd91;
    reset = 1'b1;
    update_settings_in = 1'b0;
    sys_time = '0;
    for (int i = 0; i < num_segment; i++) begin
      settings[i] = '{freq_div: divisor_t'(1), cycle: '0};
    end
    repeat (reset_cycles) tick();
    reset = 1'b0;
    for (int r = 0; r < num_requests; r++) begin
      dones = done_count;
      issue_request(r == zero_cycle_req);
      waited = 0;
      while (done_count == dones) begin
        tick();
        waited++;
        if (r < num_load_requests && waited == load_req_delay) begin
          issue_request(1'b0);  // lands in LOAD and must be dropped
        end
      end
      repeat (check_cycles) tick();
    end
    if (done_count == num_requests) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("%0d done pulses seen for %0d accepted requests", done_count, num_requests);
      fail_run();
    end
  end

endmodule

// ==== project.f ====
verilog/stm_pkg.sv
verilog/pipe_divider.sv
verilog/settle_counter.sv
verilog/stm_settings_fsm.sv
verilog/stm_index_calc.sv
verilog/stm_timer.sv
bench/stm_timer_tb.sv

// ==== verilog/pipe_divider.sv ====
`timescale 1ns/1ps
module pipe_divider (
  input  logic                CLK,
  input  logic                reset,
  input  logic                in_valid,
  input  stm_pkg::dividend_t  dividend,
  input  stm_pkg::divisor_t   divisor,
  output stm_pkg::div_result_t result,
  output logic                out_valid
);
  import stm_pkg::*;

  // everything one stage hands to the next
  typedef struct packed {
    divisor_t rem;  // partial remainder
    dividend_t qd;  // dividend bits still to consume on top, quotient bits below
    divisor_t div;  // divisor travels with its operand
  } stage_t;

  stage_t stage_q [dividend_w+1];
  logic [dividend_w:0] valid_q;

  // input register, the partial remainder starts at zero
  always_ff @(posedge CLK) begin
    stage_q[0].rem <= '0;
    stage_q[0].qd <= dividend;
    stage_q[0].div <= divisor;
  end

  // one restoring step per stage, the top dividend bit moves into the remainder
  for (genvar k = 1; k <= dividend_w; k++) begin : gen_stage
    logic [divisor_w:0] trial;
    logic [divisor_w:0] diff;
    logic q_bit;

    assign trial = {stage_q[k-1].rem, stage_q[k-1].qd[dividend_w-1]};
    assign diff = trial - {1'b0, stage_q[k-1].div};
    assign q_bit = (trial >= {1'b0, stage_q[k-1].div});  // always set for a zero divisor

    always_ff @(posedge CLK) begin
      if (q_bit) begin
        stage_q[k].rem <= diff[divisor_w-1:0];
      end else begin
        stage_q[k].rem <= trial[divisor_w-1:0];
      end
      stage_q[k].qd <= {stage_q[k-1].qd[dividend_w-2:0], q_bit};
      stage_q[k].div <= stage_q[k-1].div;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[dividend_w-1:0], in_valid};
    end
  end

  assign result.quo = stage_q[dividend_w].qd;
  assign result.rem = stage_q[dividend_w].rem;
  assign out_valid = valid_q[dividend_w];

  // the strobe must line up with the data path, which has no reset
  property p_valid_delay;
    @(posedge CLK) disable iff (reset)
      1'b1 |-> ##div_latency (out_valid == $past(in_valid, div_latency));
  endproperty

  a_valid_delay: assert property (p_valid_delay)
    else $error("out_valid does not follow in_valid by %0d cycles", div_latency);

endmodule

// ==== verilog/settle_counter.sv ====
`timescale 1ns/1ps
module settle_counter (
  input  logic CLK,
  input  logic reset,
  input  logic start,
  output logic settle_done
);
  import stm_pkg::*;

  settle_cnt_t cnt;
  logic running;

  always_ff @(posedge CLK) begin
    if (reset) begin
      cnt <= '0;
      running <= 1'b0;
      settle_done <= 1'b0;
    end else if (start) begin
      cnt <= '0;
      running <= 1'b1;
      settle_done <= 1'b0;
    end else if (running) begin
      cnt <= cnt + settle_cnt_t'(1);
      // cnt is one behind the edge count since start
      if (cnt == settle_cnt_t'(settle_latency - 1)) begin
        running <= 1'b0;
        settle_done <= 1'b1;
      end else begin
        settle_done <= 1'b0;
      end
    end else begin
      settle_done <= 1'b0;
    end
  end

  // a second load before the first has settled would cut the wait short
  a_no_restart: assert property (
    @(posedge CLK) disable iff (reset) start |-> !running
  ) else $error("settle counter restarted while running");

endmodule

// ==== verilog/stm_index_calc.sv ====
`timescale 1ns/1ps
module stm_index_calc (
  input  logic                   CLK,
  input  logic                   reset,
  input  logic                   load_settings,
  input  stm_pkg::stm_settings_t settings,
  input  stm_pkg::sys_time_t     sys_time,
  output stm_pkg::idx_t          idx
);
  import stm_pkg::*;

  divisor_t freq_div;
  divisor_t cycle_len;  // cycle setting plus one, up to 8192

  div_result_t cnt_result;
  logic cnt_valid;
  div_result_t idx_result;
  logic idx_valid;

  always_ff @(posedge CLK) begin
    if (reset) begin
      freq_div <= divisor_t'(1);
      cycle_len <= divisor_t'(1);
    end else if (load_settings) begin
      freq_div <= settings.freq_div;
      cycle_len <= divisor_t'(settings.cycle) + divisor_t'(1);
    end
  end

  // number of whole divider periods since time zero
  pipe_divider div_cnt (
    .CLK      (CLK),
    .reset    (reset),
    .in_valid (1'b1),
    .dividend (sys_time[sys_time_w-1:time_shift]),
    .divisor  (freq_div),
    .result   (cnt_result),
    .out_valid(cnt_valid)
  );

  // position inside the current cycle
  pipe_divider div_idx (
    .CLK      (CLK),
    .reset    (reset),
    .in_valid (cnt_valid),
    .dividend (cnt_result.quo),
    .divisor  (cycle_len),
    .result   (idx_result),
    .out_valid(idx_valid)
  );

  // the remainder is below cycle_len, so it always fits the index width
  always_ff @(posedge CLK) begin
    if (reset) begin
      idx <= '0;
    end else if (idx_valid) begin
      idx <= idx_result.rem[idx_w-1:0];
    end
  end

  // the host never programs a zero divider
  a_freq_div_nonzero: assert property (
    @(posedge CLK) disable iff (reset) freq_div != '0
  ) else $error("freq_div is zero");

endmodule

// ==== verilog/stm_pkg.sv ====
package stm_pkg;

  localparam int num_segment = 2;

  localparam int sys_time_w = 57;
  localparam int time_shift = 9;
  localparam int dividend_w = 48;
  localparam int divisor_w = 16;
  localparam int idx_w = 13;

  // one register per quotient bit plus the input register
  localparam int div_latency = dividend_w + 1;
  // two dividers, the settings register, the index register and one spare cycle
  localparam int settle_latency = 2 * div_latency + 3;
  localparam int settle_cnt_w = $clog2(settle_latency + 1);

  typedef logic [sys_time_w-1:0] sys_time_t;
  typedef logic [dividend_w-1:0] dividend_t;
  typedef logic [divisor_w-1:0] divisor_t;
  typedef logic [idx_w-1:0] idx_t;
  typedef logic [idx_w-1:0] cycle_t;  // number of samples minus one
  typedef logic [settle_cnt_w-1:0] settle_cnt_t;

  typedef struct packed {
    divisor_t freq_div;
    cycle_t cycle;
  } stm_settings_t;

  typedef struct packed {
    dividend_t quo;
    divisor_t rem;
  } div_result_t;

  typedef enum logic {
    IDLE,
    LOAD
  } settings_state_t;

endpackage

// ==== verilog/stm_settings_fsm.sv ====
`timescale 1ns/1ps
module stm_settings_fsm (
  input  logic CLK,
  input  logic reset,
  input  logic update_settings_in,
  input  logic settle_done,
  output logic load_settings,
  output logic update_settings_out
);
  import stm_pkg::*;

  settings_state_t state;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= IDLE;
      load_settings <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          load_settings <= update_settings_in;
          if (update_settings_in) begin
            state <= LOAD;
          end
        end
        LOAD: begin
          load_settings <= 1'b0;  // requests are dropped here
          if (settle_done) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
          load_settings <= 1'b0;
        end
      endcase
    end
  end

  // done goes out in the same cycle the counter expires
  assign update_settings_out = (state == LOAD) && settle_done;

  // the counter is only started from here, so it can only expire during LOAD
  a_done_in_load: assert property (
    @(posedge CLK) disable iff (reset) settle_done |-> (state == LOAD)
  ) else $error("settle_done outside LOAD");

endmodule

// ==== verilog/stm_timer.sv ====
`timescale 1ns/1ps
module stm_timer (
  input  logic                   CLK,
  input  logic                   reset,
  input  logic                   update_settings_in,
  input  stm_pkg::sys_time_t     sys_time,
  input  stm_pkg::stm_settings_t settings [stm_pkg::num_segment],
  output stm_pkg::idx_t          idx [stm_pkg::num_segment],
  output logic                   update_settings_out
);
  import stm_pkg::*;

  logic load_settings;  // one cycle, shared by all segments
  logic settle_done;

  stm_settings_fsm fsm_i (
    .CLK                (CLK),
    .reset              (reset),
    .update_settings_in (update_settings_in),
    .settle_done        (settle_done),
    .load_settings      (load_settings),
    .update_settings_out(update_settings_out)
  );

  // measures the pipeline refill after the settings registers change
  settle_counter settle_i (
    .CLK        (CLK),
    .reset      (reset),
    .start      (load_settings),
    .settle_done(settle_done)
  );

  // all segments see the same time, each with its own settings
  for (genvar i = 0; i < num_segment; i++) begin : gen_segment
    stm_index_calc index_calc_i (
      .CLK          (CLK),
      .reset        (reset),
      .load_settings(load_settings),
      .settings     (settings[i]),
      .sys_time     (sys_time),
      .idx          (idx[i])
    );
  end

endmodule
